/* hw/minimig_glue_pkg.sv */
// Shared types for the board glue
// All bus addresses are byte addresses, slave halves are 16-bit aligned
// Err on either bus is only meaningful in the ack cycle
package minimig_glue_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int QADR_W   = 23;  // Byte address, both sides
  localparam int MDAT_W   = 32;  // Master data
  localparam int SDAT_W   = 16;  // Slave data
  localparam int SAMPLE_W = 15;  // Signed audio sample

  //////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                cs;
    logic                we;
    logic [QADR_W-1:0]   adr;
    logic [MDAT_W/8-1:0] sel;    // Bit 3 strobes dat_w[31:24]
    logic [MDAT_W-1:0]   dat_w;
  } qmem32_req_t;

  typedef struct packed {
    logic [MDAT_W-1:0] dat_r;
    logic              ack;    // Single-cycle pulse
    logic              err;
  } qmem32_rsp_t;

  typedef struct packed {
    logic                cs;
    logic                we;
    logic [QADR_W-1:0]   adr;
    logic [SDAT_W/8-1:0] sel;
    logic [SDAT_W-1:0]   dat_w;
  } qmem16_req_t;

  typedef struct packed {
    logic [SDAT_W-1:0] dat_r;
    logic              ack;
    logic              err;
  } qmem16_rsp_t;

  //////////////////////////////////////////////////
  // Configuration and states
  //////////////////////////////////////////////////
  typedef struct packed {
    logic uart_sel;    // High routes UART to controller
    logic aud_swap;    // Exchange left and right
    logic aud_mix;     // Centre mix
    logic scan_15khz;  // Scandoubler off
  } glue_cfg_t;

  typedef enum logic [1:0] {
    RST_WAIT, RST_HOLD_CORE, RST_HOLD_CPU, RST_RUN
  } rst_state_e;

  typedef enum logic [1:0] {
    BR_IDLE, BR_HIGH, BR_LOW, BR_DONE
  } bridge_state_e;

endpackage

/* hw/board_ctrl.sv */
// Board control: input sync, reset sequencing, config decode, UART/SPI routing
// pll_locked is taken as already on the clk domain
// key inputs are active low buttons, key[1] restarts only the CPU reset
// RESET_HOLD must be at least 2
module board_ctrl #(
  parameter int RESET_HOLD = 8
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        pll_locked,
  input  logic [1:0]                  key,
  input  logic [3:0]                  sw,
  input  logic                        uart_rxd,
  output logic                        uart_txd,
  input  logic                        ctrl_txd,
  output logic                        ctrl_rxd,
  input  logic                        core_txd,
  output logic                        core_rxd,
  input  logic                        sd_dat,
  input  logic                        spi_cs_n0,
  input  logic                        core_sdo,
  output logic                        spi_di,
  output minimig_glue_pkg::glue_cfg_t cfg,
  output logic                        scan_15khz,
  output logic                        rst_sys,
  output logic                        rst_minimig,
  output logic                        rst_cpu
);

  localparam int CNT_W = $clog2(RESET_HOLD + 1);
  localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(RESET_HOLD - 1);

  logic [3:0]                       sw_meta, sw_sync;
  logic [1:0]                       key_meta, key_sync;
  logic                             run_ok;
  minimig_glue_pkg::rst_state_e     state;
  logic [CNT_W-1:0]                 hold_cnt;

  //////////////////////////////////////////////////
  // Synchronizers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      key_meta <= '0;  // Keys read as pressed
      key_sync <= '0;
    end else begin
      sw_meta  <= sw;
      sw_sync  <= sw_meta;
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  //////////////////////////////////////////////////
  // Reset sequencer
  //////////////////////////////////////////////////
  assign run_ok = pll_locked & key_sync[0];  // Lock and key0 released

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= minimig_glue_pkg::RST_WAIT;
      hold_cnt <= '0;
    end else if (!run_ok) begin
      state    <= minimig_glue_pkg::RST_WAIT;  // Abort from any state
      hold_cnt <= '0;
    end else begin
      case (state)
        minimig_glue_pkg::RST_WAIT: begin
          state    <= minimig_glue_pkg::RST_HOLD_CORE;
          hold_cnt <= '0;
        end
        minimig_glue_pkg::RST_HOLD_CORE: begin
          hold_cnt <= (hold_cnt == HOLD_LAST) ? '0 : hold_cnt + 1'b1;
          if (hold_cnt == HOLD_LAST) state <= minimig_glue_pkg::RST_HOLD_CPU;
        end
        minimig_glue_pkg::RST_HOLD_CPU: begin
          hold_cnt <= (hold_cnt == HOLD_LAST) ? '0 : hold_cnt + 1'b1;
          if (hold_cnt == HOLD_LAST) state <= minimig_glue_pkg::RST_RUN;
        end
        default: begin
          if (!key_sync[1]) state <= minimig_glue_pkg::RST_HOLD_CPU;  // CPU-only restart
        end
      endcase
    end
  end

  assign rst_sys     = (state == minimig_glue_pkg::RST_WAIT) ||
                       (state == minimig_glue_pkg::RST_HOLD_CORE);
  assign rst_minimig = rst_sys;                             // Core leaves reset with glue
  assign rst_cpu     = (state != minimig_glue_pkg::RST_RUN);

  //////////////////////////////////////////////////
  // Config decode and routing
  //////////////////////////////////////////////////
  assign cfg.uart_sel   = sw_sync[0];
  assign cfg.scan_15khz = sw_sync[1];
  assign cfg.aud_swap   = sw_sync[2];
  assign cfg.aud_mix    = sw_sync[3];
  assign scan_15khz     = cfg.scan_15khz;

  assign uart_txd = cfg.uart_sel ? ctrl_txd : core_txd;
  assign ctrl_rxd = cfg.uart_sel ? uart_rxd : 1'b1;   // Idle high when deselected
  assign core_rxd = cfg.uart_sel ? 1'b1 : uart_rxd;
  assign spi_di   = !spi_cs_n0 ? sd_dat : core_sdo;   // SD card owns CS0

  a_cpu_after_core: assert property (@(posedge clk) disable iff (!arst_n)
    rst_minimig |-> rst_cpu)
    else $error("CPU out of reset before core");

  a_cpu_hold_len: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(rst_cpu) |-> !rst_minimig && $past(!rst_minimig, RESET_HOLD))
    else $error("CPU reset released too early");

endmodule

/* hw/qmem_bridge.sv */
// 32-to-16 bit qmem bridge, single clock
// Upper half first at the word address, lower half at word address + 2
// Halves with no byte strobes are skipped and read back as zero
// Master must hold its request stable until ack
module qmem_bridge (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          rst,
  input  minimig_glue_pkg::qmem32_req_t m_req,
  output minimig_glue_pkg::qmem32_rsp_t m_rsp,
  output minimig_glue_pkg::qmem16_req_t s_req,
  input  minimig_glue_pkg::qmem16_rsp_t s_rsp
);

  localparam int SDW = minimig_glue_pkg::SDAT_W;
  localparam int MDW = minimig_glue_pkg::MDAT_W;
  localparam int AW  = minimig_glue_pkg::QADR_W;

  minimig_glue_pkg::bridge_state_e state, state_nxt;
  logic           hi_used, lo_used;
  logic           is_low;
  logic           start;
  logic [SDW-1:0] dat_hi, dat_lo;
  logic           err_q;

  assign hi_used = |m_req.sel[3:2];
  assign lo_used = |m_req.sel[1:0];
  assign is_low  = (state == minimig_glue_pkg::BR_LOW);
  assign start   = (state == minimig_glue_pkg::BR_IDLE) && m_req.cs;

  //////////////////////////////////////////////////
  // Slave request
  //////////////////////////////////////////////////
  always_comb begin
    s_req.cs    = (state == minimig_glue_pkg::BR_HIGH) || is_low;
    s_req.we    = m_req.we;
    s_req.adr   = {m_req.adr[AW-1:2], is_low, 1'b0};  // +2 for the lower half
    s_req.sel   = is_low ? m_req.sel[1:0] : m_req.sel[3:2];
    s_req.dat_w = is_low ? m_req.dat_w[SDW-1:0] : m_req.dat_w[MDW-1:SDW];
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      minimig_glue_pkg::BR_IDLE: begin
        if (m_req.cs) begin
          if (hi_used)      state_nxt = minimig_glue_pkg::BR_HIGH;
          else if (lo_used) state_nxt = minimig_glue_pkg::BR_LOW;
          else              state_nxt = minimig_glue_pkg::BR_DONE;  // Nothing to move
        end
      end
      minimig_glue_pkg::BR_HIGH: begin
        if (s_rsp.ack) state_nxt = lo_used ? minimig_glue_pkg::BR_LOW
                                           : minimig_glue_pkg::BR_DONE;
      end
      minimig_glue_pkg::BR_LOW: begin
        if (s_rsp.ack) state_nxt = minimig_glue_pkg::BR_DONE;
      end
      default: state_nxt = minimig_glue_pkg::BR_IDLE;  // Ack cycle
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= minimig_glue_pkg::BR_IDLE;
      err_q <= 1'b0;
    end else if (rst) begin
      state <= minimig_glue_pkg::BR_IDLE;
      err_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (start)                    err_q <= 1'b0;
      else if (s_req.cs && s_rsp.ack) err_q <= err_q | s_rsp.err;  // OR of halves
    end
  end

  // Read data gather
  always_ff @(posedge clk) begin
    if (start) begin
      dat_hi <= '0;
      dat_lo <= '0;
    end else if (s_rsp.ack) begin
      if (state == minimig_glue_pkg::BR_HIGH) dat_hi <= s_rsp.dat_r;
      if (is_low)                             dat_lo <= s_rsp.dat_r;
    end
  end

  //////////////////////////////////////////////////
  // Master response
  //////////////////////////////////////////////////
  assign m_rsp.ack   = (state == minimig_glue_pkg::BR_DONE);
  assign m_rsp.err   = m_rsp.ack & err_q;
  assign m_rsp.dat_r = {dat_hi, dat_lo};

  a_s_req_stable: assert property (@(posedge clk) disable iff (!arst_n || rst)
    s_req.cs && !s_rsp.ack |=> $stable(s_req))
    else $error("Slave request changed before ack");

  a_m_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n || rst)
    m_rsp.ack |=> !m_rsp.ack)
    else $error("Master ack longer than one cycle");

endmodule

/* hw/audio_dac.sv */
// Audio path: channel swap, centre mix, first-order sigma-delta per channel
// DAC_BITS must not exceed SAMPLE_W
// Ones density over 2**DAC_BITS cycles equals the top offset-binary bits
module audio_dac #(
  parameter int DAC_BITS = 8
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        rst,
  input  minimig_glue_pkg::glue_cfg_t                 cfg,
  input  logic signed [minimig_glue_pkg::SAMPLE_W-1:0] ldata,
  input  logic signed [minimig_glue_pkg::SAMPLE_W-1:0] rdata,
  output logic                                        audio_left,
  output logic                                        audio_right
);

  localparam int SMP_W = minimig_glue_pkg::SAMPLE_W;

  logic signed [SMP_W-1:0] smp_q [2];  // 0 left, 1 right
  logic signed [SMP_W-1:0] chan  [2];  // After swap
  logic [1:0]              dac_bit;

  always_ff @(posedge clk) begin
    smp_q[0] <= ldata;
    smp_q[1] <= rdata;
  end

  assign chan[0] = cfg.aud_swap ? smp_q[1] : smp_q[0];
  assign chan[1] = cfg.aud_swap ? smp_q[0] : smp_q[1];

  //////////////////////////////////////////////////
  // Mix and modulator
  //////////////////////////////////////////////////
  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic signed [SMP_W+1:0] own_x, oth_x;
    logic signed [SMP_W+1:0] mix_sum;
    logic signed [SMP_W-1:0] mixed;
    logic [SMP_W-1:0]        offs;
    logic [DAC_BITS-1:0]     acc;
    logic [DAC_BITS:0]       acc_nxt;
    logic                    bit_q;

    assign own_x   = (SMP_W+2)'(chan[ch]);      // Sign extended
    assign oth_x   = (SMP_W+2)'(chan[1-ch]);
    assign mix_sum = (own_x <<< 1) + own_x + oth_x;  // 3*own + other
    assign mixed   = cfg.aud_mix ? mix_sum[SMP_W+1:2] : chan[ch];  // >>> 2
    assign offs    = {~mixed[SMP_W-1], mixed[SMP_W-2:0]};           // Offset binary
    assign acc_nxt = {1'b0, acc} + {1'b0, offs[SMP_W-1 -: DAC_BITS]};

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        acc   <= '0;
        bit_q <= 1'b0;
      end else if (rst) begin
        acc   <= '0;
        bit_q <= 1'b0;
      end else begin
        acc   <= acc_nxt[DAC_BITS-1:0];
        bit_q <= acc_nxt[DAC_BITS];  // Carry is the pulse
      end
    end

    assign dac_bit[ch] = bit_q;
  end

  assign audio_left  = dac_bit[0];
  assign audio_right = dac_bit[1];

endmodule

/* hw/activity_leds.sv */
// Activity LEDs with pulse stretching, low track bits on the lower LEDs
// Upper track bits are not shown
module activity_leds #(
  parameter int STRETCH_CYCLES = 16
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rst,
  input  logic       floppy_wr,
  input  logic       floppy_rd,
  input  logic       hd_wr,
  input  logic       hd_rd,
  input  logic [7:0] track,
  output logic [7:0] led_g
);

  localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(STRETCH_CYCLES);

  logic [3:0] act;    // Bit 3 is floppy write
  logic [3:0] lit;
  logic [3:0] trk_q;

  assign act = {floppy_wr, floppy_rd, hd_wr, hd_rd};

  //////////////////////////////////////////////////
  // Pulse stretchers
  //////////////////////////////////////////////////
  for (genvar i = 0; i < 4; i++) begin : g_stretch
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        cnt <= '0;
      end else if (rst) begin
        cnt <= '0;
      end else if (act[i]) begin
        cnt <= CNT_LOAD;         // Retrigger
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end

    assign lit[i] = (cnt != '0);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)  trk_q <= '0;
    else if (rst) trk_q <= '0;
    else          trk_q <= track[3:0];
  end

  assign led_g = {lit, trk_q};

endmodule

/* hw/minimig_glue_top.sv */
// Board glue top level, single clock
// Host bus is the 32-bit master side, sd bus goes to the SDRAM controller
// Core resets are active high
module minimig_glue_top #(
  parameter int RESET_HOLD     = 8,
  parameter int DAC_BITS       = 8,
  parameter int STRETCH_CYCLES = 16
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        pll_locked,
  input  logic [1:0]                                  key,       // Active low
  input  logic [3:0]                                  sw,
  // UART
  input  logic                                        uart_rxd,
  output logic                                        uart_txd,
  input  logic                                        ctrl_txd,
  output logic                                        ctrl_rxd,
  input  logic                                        core_txd,
  output logic                                        core_rxd,
  // SPI
  input  logic                                        sd_dat,
  input  logic                                        spi_cs_n0,
  input  logic                                        core_sdo,
  output logic                                        spi_di,
  // Core control
  output logic                                        scan_15khz,
  output logic                                        rst_minimig,
  output logic                                        rst_cpu,
  // Memory buses
  input  minimig_glue_pkg::qmem32_req_t               host_req,
  output minimig_glue_pkg::qmem32_rsp_t               host_rsp,
  output minimig_glue_pkg::qmem16_req_t               sd_req,
  input  minimig_glue_pkg::qmem16_rsp_t               sd_rsp,
  // Audio
  input  logic signed [minimig_glue_pkg::SAMPLE_W-1:0] ldata,
  input  logic signed [minimig_glue_pkg::SAMPLE_W-1:0] rdata,
  output logic                                        audio_left,
  output logic                                        audio_right,
  // Indicators
  input  logic                                        floppy_wr,
  input  logic                                        floppy_rd,
  input  logic                                        hd_wr,
  input  logic                                        hd_rd,
  input  logic [7:0]                                  track,
  output logic [7:0]                                  led_g
);

  logic                        rst_sys;  // Glue reset, active high
  minimig_glue_pkg::glue_cfg_t cfg;

  //////////////////////////////////////////////////
  // Modules
  //////////////////////////////////////////////////
  board_ctrl #(.RESET_HOLD(RESET_HOLD)) i_board_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .pll_locked  (pll_locked),
    .key         (key),
    .sw          (sw),
    .uart_rxd    (uart_rxd),
    .uart_txd    (uart_txd),
    .ctrl_txd    (ctrl_txd),
    .ctrl_rxd    (ctrl_rxd),
    .core_txd    (core_txd),
    .core_rxd    (core_rxd),
    .sd_dat      (sd_dat),
    .spi_cs_n0   (spi_cs_n0),
    .core_sdo    (core_sdo),
    .spi_di      (spi_di),
    .cfg         (cfg),
    .scan_15khz  (scan_15khz),
    .rst_sys     (rst_sys),
    .rst_minimig (rst_minimig),
    .rst_cpu     (rst_cpu)
  );

  qmem_bridge i_qmem_bridge (
    .clk    (clk),
    .arst_n (arst_n),
    .rst    (rst_sys),
    .m_req  (host_req),
    .m_rsp  (host_rsp),
    .s_req  (sd_req),
    .s_rsp  (sd_rsp)
  );

  audio_dac #(.DAC_BITS(DAC_BITS)) i_audio_dac (
    .clk         (clk),
    .arst_n      (arst_n),
    .rst         (rst_sys),
    .cfg         (cfg),
    .ldata       (ldata),
    .rdata       (rdata),
    .audio_left  (audio_left),
    .audio_right (audio_right)
  );

  activity_leds #(.STRETCH_CYCLES(STRETCH_CYCLES)) i_activity_leds (
    .clk       (clk),
    .arst_n    (arst_n),
    .rst       (rst_sys),
    .floppy_wr (floppy_wr),
    .floppy_rd (floppy_rd),
    .hd_wr     (hd_wr),
    .hd_rd     (hd_rd),
    .track     (track),
    .led_g     (led_g)
  );

endmodule

/* verification/tb_checks.svh */
// Check tasks included inside the testbench module
// Inputs change 1 ns after a rising edge
// Outputs are read at falling edges
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic int step_len(string kind, logic [31:0] d);
  case (kind)
    "RST":   return 4 * RESET_HOLD + 20;
    "WR":    return 12;                  // Two halves of at most 4 cycles each
    "RD":    return 12;
    "AUD":   return 262;
    "RT":    return 4;
    "LED":   return int'(d) + 6;
    default: return 10;
  endcase
endfunction

task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
  checks++;
  assert (exp === act) else begin
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_reset(string name);
  int n;
  @(posedge clk);
  #1 pll_locked = 1'b1;                  // key[0] already released
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (rst_minimig && n < 40);
  checks++;
  assert (n >= RESET_HOLD && n <= RESET_HOLD + 4) else begin
    errors++;
    $display("CHECK FAILED %s: expected %0d to %0d cycles, actual %0d",
             name, RESET_HOLD, RESET_HOLD + 4, n);
  end
  n = 0;
  while (rst_cpu && n < 40) begin
    @(negedge clk);
    n++;
  end
  check_value({name, "_cpu"}, RESET_HOLD, n);
  @(posedge clk);
  #1 key = 2'b10;                        // Press key[0]
  n = 0;
  do begin
    @(posedge clk);                      // One clock edge per counted cycle
    @(negedge clk);
    n++;
  end while (!(rst_minimig && rst_cpu) && n < 10);
  checks++;
  assert (n <= 3) else begin
    errors++;
    $display("CHECK FAILED %s_key: expected at most 3 cycles, actual %0d", name, n);
  end
  @(posedge clk);
  #1 key = 2'b11;
  while (rst_cpu) @(negedge clk);        // Back to run
endtask

task automatic check_bus(string name, bit we, logic [31:0] adr, logic [31:0] sel,
                         logic [31:0] val, logic [31:0] exp_err);
  int          reqs0;
  int          halves;
  logic [31:0] rd;
  logic        er;
  reqs0  = slave_reqs;
  halves = int'(|sel[3:2]) + int'(|sel[1:0]);  // Skipped halves make no request
  @(posedge clk);
  #1;
  host_req.cs    = 1'b1;
  host_req.we    = we;
  host_req.adr   = adr[22:0];
  host_req.sel   = sel[3:0];
  host_req.dat_w = we ? val : '0;
  do @(negedge clk); while (!host_rsp.ack);
  rd = host_rsp.dat_r;
  er = host_rsp.err;
  @(posedge clk);
  #1 host_req.cs = 1'b0;
  check_value({name, "_err"}, exp_err, 32'(er));
  if (!we) check_value({name, "_data"}, val, rd);
  check_value({name, "_reqs"}, halves, slave_reqs - reqs0);
endtask

task automatic check_audio(string name, logic [31:0] swv, logic [31:0] lv,
                           logic [31:0] rv, logic [31:0] exp);
  int ones_l;
  int ones_r;
  @(posedge clk);
  #1;
  sw    = swv[3:0];
  ldata = lv[14:0];
  rdata = rv[14:0];
  repeat (6) @(posedge clk);             // Sync, sample register, settle
  ones_l = 0;
  ones_r = 0;
  repeat (256) begin
    @(negedge clk);
    ones_l += int'(audio_left);
    ones_r += int'(audio_right);
  end
  check_value({name, "_left"}, exp[15:8], ones_l);
  check_value({name, "_right"}, exp[7:0], ones_r);
endtask

task automatic check_route(string name, logic [31:0] swv, logic [31:0] cs_n,
                           logic [31:0] ins, logic [31:0] exp);
  @(posedge clk);
  #1;
  sw        = swv[3:0];
  spi_cs_n0 = cs_n[0];
  {uart_rxd, ctrl_txd, core_txd, sd_dat, core_sdo} = ins[4:0];
  repeat (3) @(posedge clk);
  @(negedge clk);
  check_value(name, exp[4:0], {uart_txd, ctrl_rxd, core_rxd, spi_di, scan_15khz});
endtask

task automatic check_leds(string name, logic [31:0] which, logic [31:0] trk,
                          logic [31:0] exp_low, logic [31:0] len);
  int bitpos;
  bitpos = 4 + int'(which[1:0]);         // Input 3 is floppy write on led 7
  @(posedge clk);
  #1;
  track = trk[7:0];
  {floppy_wr, floppy_rd, hd_wr, hd_rd} = 4'b0001 << which[1:0];
  @(posedge clk);
  #1 {floppy_wr, floppy_rd, hd_wr, hd_rd} = 4'b0000;
  for (int k = 1; k <= int'(len); k++) begin
    @(negedge clk);
    check_value({name, "_lit"}, 1, 32'(led_g[bitpos]));
  end
  repeat (2) @(negedge clk);
  check_value({name, "_dark"}, 0, 32'(led_g[bitpos]));
  check_value({name, "_track"}, exp_low, led_g[3:0]);
endtask

`endif

/* verification/tb_minimig_glue.sv */
// Testbench for the board glue top level
// Steps come from verification/glue_stim.txt, read from the project root
// Slave memory model acks after 1 to 4 cycles and errs on one address
// Run is cut off at 20 times the summed step lengths
module tb_minimig_glue;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_HOLD     = 8;
  localparam int DAC_BITS       = 8;
  localparam int STRETCH_CYCLES = 16;
  localparam logic [22:0] ERR_ADR = 23'h000404;  // Slave address that errs

  logic        clk;
  logic        arst_n;
  logic        pll_locked;
  logic [1:0]  key;
  logic [3:0]  sw;
  logic        uart_rxd, uart_txd, ctrl_txd, ctrl_rxd, core_txd, core_rxd;
  logic        sd_dat, spi_cs_n0, core_sdo, spi_di;
  logic        scan_15khz, rst_minimig, rst_cpu;
  minimig_glue_pkg::qmem32_req_t host_req;
  minimig_glue_pkg::qmem32_rsp_t host_rsp;
  minimig_glue_pkg::qmem16_req_t sd_req;
  minimig_glue_pkg::qmem16_rsp_t sd_rsp;
  logic signed [minimig_glue_pkg::SAMPLE_W-1:0] ldata, rdata;
  logic        audio_left, audio_right;
  logic        floppy_wr, floppy_rd, hd_wr, hd_rd;
  logic [7:0]  track, led_g;

  int          errors, checks, slave_reqs, cycles, limit;
  logic [15:0] mem [int];        // Slave memory, 16-bit words
  string       st_name [$];
  string       st_kind [$];
  logic [31:0] st_a [$], st_b [$], st_c [$], st_d [$];

  minimig_glue_top #(
    .RESET_HOLD     (RESET_HOLD),
    .DAC_BITS       (DAC_BITS),
    .STRETCH_CYCLES (STRETCH_CYCLES)
  ) i_minimig_glue_top (.*);

  `include "tb_checks.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;       // 10 ns period
  end

  //////////////////////////////////////////////////
  // Slave memory model
  //////////////////////////////////////////////////
  function automatic logic [15:0] mem_read(int idx);
    if (mem.exists(idx)) return mem[idx];
    return 16'(idx ^ (idx >> 7) ^ 16'h5a5a);  // Fill from whole word address
  endfunction

  initial begin
    int          delay;
    int          idx;
    logic [15:0] cur;
    sd_rsp = '0;
    forever begin
      @(negedge clk);
      if (sd_req.cs) begin
        slave_reqs++;
        delay = 1 + int'($urandom % 4);
        repeat (delay) @(posedge clk);
        #1;
        idx = int'(sd_req.adr[22:1]);
        cur = mem_read(idx);
        sd_rsp.ack = 1'b1;
        if (sd_req.adr == ERR_ADR) begin
          sd_rsp.err   = 1'b1;           // No write, zero data
          sd_rsp.dat_r = '0;
        end else if (sd_req.we) begin
          if (sd_req.sel[1]) cur[15:8] = sd_req.dat_w[15:8];
          if (sd_req.sel[0]) cur[7:0]  = sd_req.dat_w[7:0];
          mem[idx] = cur;
        end else begin
          sd_rsp.dat_r = cur;
        end
        @(posedge clk);
        #1 sd_rsp = '0;                  // Single-cycle ack
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: run exceeded %0d cycles", limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus file and main sequence
  //////////////////////////////////////////////////
  task automatic load_steps();
    int          fd;
    int          n;
    string       line, nm, kd;
    logic [31:0] a, b, c, d;
    fd = $fopen("verification/glue_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %s %h %h %h %h", nm, kd, a, b, c, d);
      if (n < 2) continue;
      st_name.push_back(nm);
      st_kind.push_back(kd);
      st_a.push_back(a);
      st_b.push_back(b);
      st_c.push_back(c);
      st_d.push_back(d);
    end
    $fclose(fd);
  endtask

  initial begin
    int sum;
    void'($urandom(32'h7c35_be0a));
    errors = 0;
    checks = 0;
    slave_reqs = 0;
    cycles = 0;
    limit = 100000;                      // Until the steps are loaded
    arst_n = 1'b0;
    pll_locked = 1'b0;
    key = 2'b11;                         // Buttons released
    sw = '0;
    {uart_rxd, ctrl_txd, core_txd, sd_dat, core_sdo} = 5'b11111;
    spi_cs_n0 = 1'b1;
    host_req = '0;
    ldata = '0;
    rdata = '0;
    {floppy_wr, floppy_rd, hd_wr, hd_rd} = 4'b0000;
    track = '0;
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;
    load_steps();
    sum = 0;
    foreach (st_kind[i]) sum += step_len(st_kind[i], st_d[i]);
    limit = cycles + 20 * sum;
    foreach (st_kind[i]) begin
      case (st_kind[i])
        "RST":   check_reset(st_name[i]);
        "WR":    check_bus(st_name[i], 1'b1, st_a[i], st_b[i], st_c[i], st_d[i]);
        "RD":    check_bus(st_name[i], 1'b0, st_a[i], st_b[i], st_c[i], st_d[i]);
        "AUD":   check_audio(st_name[i], st_a[i], st_b[i], st_c[i], st_d[i]);
        "RT":    check_route(st_name[i], st_a[i], st_b[i], st_c[i], st_d[i]);
        "LED":   check_leds(st_name[i], st_a[i], st_b[i], st_c[i], st_d[i]);
        default: begin
          errors++;
          $display("Unknown step kind %s in step %s", st_kind[i], st_name[i]);
        end
      endcase
    end
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("test passed");
    else             $display("test failed");
    $finish;
  end

endmodule

/* verification/glue_stim.txt */
# name kind a b c d, operands in hex
# WR: adr sel wdata err, RD: adr sel rdata err, AUD: sw ldata rdata {left,right} ones
# RT: sw spi_cs_n0 {uart_rxd,ctrl_txd,core_txd,sd_dat,core_sdo} {uart_txd,ctrl_rxd,core_rxd,spi_di,scan}
# LED: input(3 fwr,2 frd,1 hwr,0 hrd) track led_low stretch; RST: no operands
reset_order    RST 0 0 0 0
wr_full        WR  100 f 11223344 0
wr_prep_a      WR  200 f 55667788 0
wr_upper       WR  200 c aaaabbbb 0
wr_prep_b      WR  300 f 99990000 0
wr_lower       WR  300 3 ccccdddd 0
wr_nosel       WR  400 0 deadbeef 0
rd_full        RD  100 f 11223344 0
rd_upper_kept  RD  200 f aaaa7788 0
rd_lower_only  RD  200 3 00007788 0
rd_lower_kept  RD  300 f 9999dddd 0
rd_upper_only  RD  300 c 99990000 0
rd_nosel       RD  400 0 00000000 0
err_write      WR  404 f 12345678 1
err_next       RD  100 f 11223344 0
err_lower      RD  404 3 00005678 0
err_read       RD  404 c 00000000 1
aud_plain      AUD 0 1000 7c00 a078
aud_swap       AUD 4 1000 7c00 78a0
aud_mix        AUD 8 1000 7c00 9682
aud_swap_mix   AUD c 1000 7c00 8296
route_core_sd  RT  0 0 0a 0a
route_ctrl     RT  1 1 05 06
route_scan     RT  2 1 19 0f
route_all      RT  3 0 1c 1d
led_fwr        LED 3 a5 5 10
led_frd        LED 2 3c c 10
led_hwr        LED 1 07 7 10
led_hrd        LED 0 f0 0 10

/* files.f */
+incdir+verification
hw/minimig_glue_pkg.sv
hw/board_ctrl.sv
hw/qmem_bridge.sv
hw/audio_dac.sv
hw/activity_leds.sv
hw/minimig_glue_top.sv
verification/tb_minimig_glue.sv

/* Bender.yml */
package:
  name: minimig_glue

sources:
  - hw/minimig_glue_pkg.sv
  - hw/board_ctrl.sv
  - hw/qmem_bridge.sv
  - hw/audio_dac.sv
  - hw/activity_leds.sv
  - hw/minimig_glue_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_minimig_glue.sv
